// File: design/div_params.svh
// Divide unit widths
`ifndef DIV_PARAMS_SVH
`define DIV_PARAMS_SVH

// --------------------------------------------------
// Datapath widths
// --------------------------------------------------
`define DIV_A_WIDTH   16	// Dividend and quotient
`define DIV_B_WIDTH   8	// Divisor

// --------------------------------------------------
// Bookkeeping widths
// --------------------------------------------------
`define DIV_TAG_WIDTH 4	// Tag that travels with each divide

// Divide-by-zero event counter, sticks at all ones
`define DIV_CNT_WIDTH 8

`endif

// File: design/div_cmd_pkg.sv
// Divide command opcodes
package div_cmd_pkg;

	// --------------------------------------------------
	// Command opcode
	// --------------------------------------------------
	// The opcode arrives with the command strobe.
	// Only the two divide opcodes start work in the
	// execute stage. A clear only touches the result
	// stage bookkeeping. A no-op is dropped in decode.
	typedef enum logic [1:0]
	{
		OP_NOP  = 2'b00,	// No result
		OP_DIVU = 2'b01,	// Unsigned divide
		OP_DIVS = 2'b10,	// Signed divide, truncates toward zero
		OP_CLR  = 2'b11	// Clears sticky error and counter
	} div_op_t;

	// Bit 0 set with bit 1 clear selects unsigned,
	// bit 1 set with bit 0 clear selects signed.
	// Both bits set is the clear request, so decode
	// compares the whole code rather than single bits

endpackage

// File: design/div_status_pkg.sv
// Divide result status codes
package div_status_pkg;

	// --------------------------------------------------
	// Result status
	// --------------------------------------------------
	// Returned with every quotient. Divide-by-zero
	// wins over overflow when both core flags are set,
	// which the core does not produce today anyway
	typedef enum logic [1:0]
	{
		ST_OK       = 2'b00,	// Normal quotient
		ST_DIV_ZERO = 2'b01,	// Zero divisor, saturated quotient
		ST_OVERFLOW = 2'b10,	// Most negative over minus one
		ST_RSVD     = 2'b11	// Not produced
	} div_status_t;

	// Any code other than ST_OK raises the sticky
	// error flag in the result stage

endpackage

// File: design/div_core.sv
// Combinational integer divider
`timescale 1ns/1ps
`include "div_params.svh"

module div_core
#(
	parameter bit tc_enable = 1'b1	// Zero compiles signed mode out
)
(
	input  logic [`DIV_A_WIDTH-1:0] a,	// Dividend
	input  logic [`DIV_B_WIDTH-1:0] b,	// Divisor
	input  logic                    tc,	// Two's complement mode
	output logic [`DIV_A_WIDTH-1:0] quotient,
	output logic                    divide_by_0,
	output logic                    overflow
);

	localparam int A_W = `DIV_A_WIDTH;
	localparam int B_W = `DIV_B_WIDTH;

	// Saturation values
	localparam logic [A_W-1:0] A_MAX_POS = {1'b0, {(A_W-1){1'b1}}};
	localparam logic [A_W-1:0] A_MAX_NEG = {1'b1, {(A_W-1){1'b0}}};

	logic           signed_mode;	// Mode after the build option
	logic [A_W-1:0] a_mag;	// Dividend magnitude
	logic [B_W-1:0] b_mag;	// Divisor magnitude
	logic [A_W-1:0] q_mag;	// Unsigned quotient of magnitudes
	logic [A_W-1:0] q_signed;
	logic           neg_result;	// Operand signs differ

	// --------------------------------------------------
	// Shift/subtract core
	// --------------------------------------------------
	// Non-restoring loop, one quotient bit per dividend bit.
	// The partial remainder is one bit wider than the divisor
	// and stays in [-d, d), so its sign bit picks add or subtract
	function automatic logic [A_W-1:0] nr_divide
	(
		input logic [A_W-1:0] n,
		input logic [B_W-1:0] d
	);
		logic [B_W:0]   rem;	// Signed partial remainder
		logic [B_W:0]   d_ext;
		logic [A_W-1:0] q;
		int             i;

		rem = '0;
		d_ext = {1'b0, d};
		q = '0;
		for (i = A_W - 1; i >= 0; i--)
		begin
			if (rem[B_W])	// Negative, add back
			begin
				rem = {rem[B_W-1:0], n[i]} + d_ext;
			end
			else
			begin
				rem = {rem[B_W-1:0], n[i]} - d_ext;
			end
			q[i] = ~rem[B_W];	// Positive remainder gives a one
		end
		return q;
	endfunction

	// --------------------------------------------------
	// Operand conditioning
	// --------------------------------------------------
	assign signed_mode = tc & tc_enable;

	// Most negative dividend maps onto its own pattern, read as unsigned
	assign a_mag = (signed_mode && a[A_W-1]) ? (~a + 1'b1) : a;
	assign b_mag = (signed_mode && b[B_W-1]) ? (~b + 1'b1) : b;

	assign q_mag = nr_divide(a_mag, b_mag);

	// Negate on differing signs, truncates toward zero
	assign neg_result = signed_mode & (a[A_W-1] ^ b[B_W-1]);
	assign q_signed   = neg_result ? (~q_mag + 1'b1) : q_mag;

	// --------------------------------------------------
	// Flags and saturation
	// --------------------------------------------------
	assign divide_by_0 = ~|b;
	assign overflow    = signed_mode && (a == A_MAX_NEG) && (&b);	// -max / -1

	always_comb
	begin
		if (divide_by_0)
		begin
			if (signed_mode)
			begin
				quotient = a[A_W-1] ? A_MAX_NEG : A_MAX_POS;	// Sign of dividend
			end
			else
			begin
				quotient = {A_W{1'b1}};	// Unsigned all ones
			end
		end
		else if (overflow)
		begin
			quotient = A_MAX_POS;	// +max stands in for +2^(A_W-1)
		end
		else
		begin
			quotient = q_signed;
		end
	end

endmodule

// File: design/div_decode.sv
// Command decode stage
`timescale 1ns/1ps
`include "div_params.svh"

module div_decode
(
	input  logic                      clk,
	input  logic                      reset,	// Synchronous, active high
	input  logic                      cmd_valid,	// One-cycle strobe
	input  div_cmd_pkg::div_op_t      cmd_op,
	input  logic [`DIV_A_WIDTH-1:0]   cmd_a,
	input  logic [`DIV_B_WIDTH-1:0]   cmd_b,
	input  logic [`DIV_TAG_WIDTH-1:0] cmd_tag,
	output logic                      dec_valid,	// Divide in decode
	output logic                      dec_signed,	// Core mode
	output logic [`DIV_A_WIDTH-1:0]   dec_a,
	output logic [`DIV_B_WIDTH-1:0]   dec_b,
	output logic [`DIV_TAG_WIDTH-1:0] dec_tag,
	output logic                      dec_clr	// Clear request pulse
);

	import div_cmd_pkg::*;

	logic is_div;	// Strobe carries a divide
	logic is_clr;	// Strobe carries a clear

	// --------------------------------------------------
	// Opcode decode
	// --------------------------------------------------
	// NOP falls through both terms and is dropped here
	assign is_div = cmd_valid && ((cmd_op == OP_DIVU) || (cmd_op == OP_DIVS));
	assign is_clr = cmd_valid && (cmd_op == OP_CLR);

	// --------------------------------------------------
	// Control register
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			dec_valid <= 1'b0;
			dec_clr   <= 1'b0;
		end
		else
		begin
			dec_valid <= is_div;
			dec_clr   <= is_clr;	// Single cycle, follows the strobe
		end
	end

	// --------------------------------------------------
	// Operand register
	// --------------------------------------------------
	// loaded on divides only, idle cycles leave it still
	always_ff @(posedge clk)
	begin
		if (is_div)
		begin
			dec_a      <= cmd_a;
			dec_b      <= cmd_b;
			dec_tag    <= cmd_tag;
			dec_signed <= (cmd_op == OP_DIVS);	// Two's complement mode
		end
	end

endmodule

// File: design/div_execute.sv
// Divide execute stage
`timescale 1ns/1ps
`include "div_params.svh"

module div_execute
(
	input  logic                      clk,
	input  logic                      reset,	// Synchronous, active high
	input  logic                      dec_valid,
	input  logic                      dec_signed,
	input  logic [`DIV_A_WIDTH-1:0]   dec_a,
	input  logic [`DIV_B_WIDTH-1:0]   dec_b,
	input  logic [`DIV_TAG_WIDTH-1:0] dec_tag,
	input  logic                      dec_clr,
	output logic                      ex_valid,
	output logic [`DIV_TAG_WIDTH-1:0] ex_tag,
	output logic [`DIV_A_WIDTH-1:0]   ex_quotient,
	output logic                      ex_div_by_0,
	output logic                      ex_overflow,	// Signed -max / -1
	output logic                      ex_clr	// Clear, one stage later
);

	logic [`DIV_A_WIDTH-1:0] core_quotient;
	logic                    core_div_by_0;
	logic                    core_overflow;

	// --------------------------------------------------
	// Divider core
	// --------------------------------------------------
	// Full combinational divide sits between the decode
	// and execute registers, the longest path in the unit
	div_core
	#(
		.tc_enable (1'b1)
	)
	u_core
	(
		.a           (dec_a),
		.b           (dec_b),
		.tc          (dec_signed),
		.quotient    (core_quotient),
		.divide_by_0 (core_div_by_0),
		.overflow    (core_overflow)
	);

	// --------------------------------------------------
	// Stage registers
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ex_valid <= 1'b0;
			ex_clr   <= 1'b0;
		end
		else
		begin
			ex_valid <= dec_valid;
			ex_clr   <= dec_clr;	// Keeps clear aligned with results
		end
	end

	// Payload follows its valid, no reset
	always_ff @(posedge clk)
	begin
		if (dec_valid)
		begin
			ex_tag      <= dec_tag;
			ex_quotient <= core_quotient;
			ex_div_by_0 <= core_div_by_0;
			ex_overflow <= core_overflow;
		end
	end

endmodule

// File: design/div_result.sv
// Divide result stage
`timescale 1ns/1ps
`include "div_params.svh"

module div_result
(
	input  logic                             clk,
	input  logic                             reset,	// Synchronous, active high
	input  logic                             ex_valid,
	input  logic [`DIV_TAG_WIDTH-1:0]        ex_tag,
	input  logic [`DIV_A_WIDTH-1:0]          ex_quotient,
	input  logic                             ex_div_by_0,
	input  logic                             ex_overflow,
	input  logic                             ex_clr,
	output logic                             res_valid,	// One-cycle result strobe
	output logic [`DIV_TAG_WIDTH-1:0]        res_tag,
	output logic [`DIV_A_WIDTH-1:0]          res_quotient,
	output div_status_pkg::div_status_t      res_status,
	output logic                             err_sticky,	// Any non-OK since clear
	output logic [`DIV_CNT_WIDTH-1:0]        dz_count	// Divide-by-zero results
);

	import div_status_pkg::*;

	localparam logic [`DIV_CNT_WIDTH-1:0] CNT_MAX = {`DIV_CNT_WIDTH{1'b1}};

	div_status_t status_next;	// Status for the result in execute

	// --------------------------------------------------
	// Status encode
	// --------------------------------------------------
	// Zero divisor first, overflow only comes from signed mode
	always_comb
	begin
		if (ex_div_by_0)
			status_next = ST_DIV_ZERO;
		else if (ex_overflow)
			status_next = ST_OVERFLOW;
		else
			status_next = ST_OK;
	end

	// --------------------------------------------------
	// Result register
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
			res_valid <= 1'b0;
		else
			res_valid <= ex_valid;
	end

	always_ff @(posedge clk)
	begin
		if (ex_valid)
		begin
			res_tag      <= ex_tag;
			res_quotient <= ex_quotient;
			res_status   <= status_next;
		end
	end

	// --------------------------------------------------
	// Error bookkeeping
	// --------------------------------------------------
	// Clear has priority, a divide on the same edge is not counted
	always_ff @(posedge clk)
	begin
		if (reset || ex_clr)
		begin
			err_sticky <= 1'b0;
			dz_count   <= '0;
		end
		else if (ex_valid)
		begin
			if (status_next != ST_OK)
				err_sticky <= 1'b1;	// Held until the next clear
			if ((status_next == ST_DIV_ZERO) && (dz_count != CNT_MAX))
				dz_count <= dz_count + 1'b1;	// Saturating
		end
	end

endmodule

// File: design/div_unit.sv
// Pipelined divide unit top
`timescale 1ns/1ps
`include "div_params.svh"

module div_unit
(
	input  logic                        clk,
	input  logic                        reset,	// Synchronous, active high
	input  logic                        cmd_valid,	// Every strobe is taken
	input  div_cmd_pkg::div_op_t        cmd_op,
	input  logic [`DIV_A_WIDTH-1:0]     cmd_a,
	input  logic [`DIV_B_WIDTH-1:0]     cmd_b,
	input  logic [`DIV_TAG_WIDTH-1:0]   cmd_tag,
	output logic                        res_valid,	// Three cycles after the strobe
	output logic [`DIV_TAG_WIDTH-1:0]   res_tag,
	output logic [`DIV_A_WIDTH-1:0]     res_quotient,
	output div_status_pkg::div_status_t res_status,
	output logic                        err_sticky,
	output logic [`DIV_CNT_WIDTH-1:0]   dz_count
);

	// --------------------------------------------------
	// Decode to execute
	// --------------------------------------------------
	logic                      dec_valid;
	logic                      dec_signed;
	logic [`DIV_A_WIDTH-1:0]   dec_a;
	logic [`DIV_B_WIDTH-1:0]   dec_b;
	logic [`DIV_TAG_WIDTH-1:0] dec_tag;
	logic                      dec_clr;

	// --------------------------------------------------
	// Execute to result
	// --------------------------------------------------
	logic                      ex_valid;
	logic [`DIV_TAG_WIDTH-1:0] ex_tag;
	logic [`DIV_A_WIDTH-1:0]   ex_quotient;
	logic                      ex_div_by_0;
	logic                      ex_overflow;
	logic                      ex_clr;

	div_decode u_decode
	(
		.clk        (clk),
		.reset      (reset),
		.cmd_valid  (cmd_valid),
		.cmd_op     (cmd_op),
		.cmd_a      (cmd_a),
		.cmd_b      (cmd_b),
		.cmd_tag    (cmd_tag),
		.dec_valid  (dec_valid),
		.dec_signed (dec_signed),
		.dec_a      (dec_a),
		.dec_b      (dec_b),
		.dec_tag    (dec_tag),
		.dec_clr    (dec_clr)
	);

	div_execute u_execute
	(
		.clk         (clk),
		.reset       (reset),
		.dec_valid   (dec_valid),
		.dec_signed  (dec_signed),
		.dec_a       (dec_a),
		.dec_b       (dec_b),
		.dec_tag     (dec_tag),
		.dec_clr     (dec_clr),
		.ex_valid    (ex_valid),
		.ex_tag      (ex_tag),
		.ex_quotient (ex_quotient),
		.ex_div_by_0 (ex_div_by_0),
		.ex_overflow (ex_overflow),
		.ex_clr      (ex_clr)
	);

	div_result u_result
	(
		.clk          (clk),
		.reset        (reset),
		.ex_valid     (ex_valid),
		.ex_tag       (ex_tag),
		.ex_quotient  (ex_quotient),
		.ex_div_by_0  (ex_div_by_0),
		.ex_overflow  (ex_overflow),
		.ex_clr       (ex_clr),
		.res_valid    (res_valid),
		.res_tag      (res_tag),
		.res_quotient (res_quotient),
		.res_status   (res_status),
		.err_sticky   (err_sticky),
		.dz_count     (dz_count)
	);

endmodule

// File: testbench/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen
(
	output logic clk,
	output logic reset	// Synchronous, active high
);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;	// 40 ns period
	end

	initial
	begin
		reset = 1'b1;
		repeat (10) @(posedge clk);
		reset <= 1'b0;	// Released on the tenth edge
	end

endmodule

// File: testbench/div_unit_tb.sv
// Divide unit testbench
`timescale 1ns/1ps
`include "div_params.svh"

module div_unit_tb;

	import div_cmd_pkg::*;
	import div_status_pkg::*;

	localparam logic [`DIV_A_WIDTH-1:0] MOST_NEG = {1'b1, {(`DIV_A_WIDTH-1){1'b0}}};
	localparam logic [`DIV_A_WIDTH-1:0] MOST_POS = {1'b0, {(`DIV_A_WIDTH-1){1'b1}}};
	localparam logic [`DIV_B_WIDTH-1:0] MINUS_ONE = {`DIV_B_WIDTH{1'b1}};

	logic clk;
	logic reset;
	logic cmd_valid;
	div_op_t cmd_op;
	logic [`DIV_A_WIDTH-1:0] cmd_a;
	logic [`DIV_B_WIDTH-1:0] cmd_b;
	logic [`DIV_TAG_WIDTH-1:0] cmd_tag;
	logic res_valid;
	logic [`DIV_TAG_WIDTH-1:0] res_tag;
	logic [`DIV_A_WIDTH-1:0] res_quotient;
	div_status_t res_status;
	logic err_sticky;
	logic [`DIV_CNT_WIDTH-1:0] dz_count;

	// Scoreboard rings, written on the strobe and read on res_valid
	logic [`DIV_A_WIDTH-1:0] exp_quot [64];
	div_status_t exp_st [64];
	logic [`DIV_TAG_WIDTH-1:0] exp_tag [64];
	logic [5:0] wr_ptr;
	logic [5:0] rd_ptr;
	logic [5:0] st_ptr;	// Result whose status reaches the bookkeeping
	logic [1:0] div_line;	// Divide strobes, one bit per stage
	logic [1:0] clr_line;	// Clear strobes, one bit per stage
	logic exp_sticky;
	logic [`DIV_CNT_WIDTH-1:0] exp_dz;
	logic idle_phase = 1'b0;	// Reset seen, no command yet
	logic [`DIV_TAG_WIDTH-1:0] next_tag;
	logic is_div_cmd;
	int i;

	tb_clock_gen u_clock_gen (.clk(clk), .reset(reset));

	div_unit UUT
	(
		.clk(clk), .reset(reset), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
		.cmd_a(cmd_a), .cmd_b(cmd_b), .cmd_tag(cmd_tag), .res_valid(res_valid),
		.res_tag(res_tag), .res_quotient(res_quotient), .res_status(res_status),
		.err_sticky(err_sticky), .dz_count(dz_count)
	);

	assign is_div_cmd = cmd_valid && ((cmd_op == OP_DIVU) || (cmd_op == OP_DIVS));

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------
	function automatic logic [`DIV_A_WIDTH-1:0] expected_quotient
	(
		input logic [`DIV_A_WIDTH-1:0] a,
		input logic [`DIV_B_WIDTH-1:0] b,
		input logic sgn
	);
		int sa;
		int sb;
		int q;

		sa = $signed(a);
		sb = $signed(b);
		if (!sgn)
			q = (b == '0) ? {`DIV_A_WIDTH{1'b1}} : (a / b);	// Zero divisor gives all ones
		else if (b == '0)
			q = (sa < 0) ? MOST_NEG : MOST_POS;	// Follows dividend sign
		else if ((a == MOST_NEG) && (b == MINUS_ONE))
			q = MOST_POS;	// Saturated overflow
		else
			q = sa / sb;	// Truncates toward zero
		return q[`DIV_A_WIDTH-1:0];
	endfunction

	function automatic div_status_t expected_status
	(
		input logic [`DIV_A_WIDTH-1:0] a,
		input logic [`DIV_B_WIDTH-1:0] b,
		input logic sgn
	);
		if (b == '0)
			return ST_DIV_ZERO;
		if (sgn && (a == MOST_NEG) && (b == MINUS_ONE))
			return ST_OVERFLOW;
		return ST_OK;
	endfunction

	always @(posedge clk)
	begin
		if (reset)
		begin
			idle_phase <= 1'b1;
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			st_ptr     <= '0;
			div_line   <= '0;
			clr_line   <= '0;
			exp_sticky <= 1'b0;
			exp_dz     <= '0;
		end
		else
		begin
			if (cmd_valid)
				idle_phase <= 1'b0;
			div_line <= {div_line[0], is_div_cmd};
			clr_line <= {clr_line[0], cmd_valid && (cmd_op == OP_CLR)};
			if (clr_line[1])	// Clear wins over a same-edge result
			begin
				exp_sticky <= 1'b0;
				exp_dz     <= '0;
			end
			else if (div_line[1])
			begin
				if (exp_st[st_ptr] != ST_OK)
					exp_sticky <= 1'b1;
				if ((exp_st[st_ptr] == ST_DIV_ZERO) && (exp_dz != {`DIV_CNT_WIDTH{1'b1}}))
					exp_dz <= exp_dz + 1'b1;
			end
			if (div_line[1])
				st_ptr <= st_ptr + 1'b1;
			if (is_div_cmd)	// Push expected result
			begin
				exp_quot[wr_ptr] <= expected_quotient(cmd_a, cmd_b, cmd_op == OP_DIVS);
				exp_st[wr_ptr]   <= expected_status(cmd_a, cmd_b, cmd_op == OP_DIVS);
				exp_tag[wr_ptr]  <= cmd_tag;
				wr_ptr           <= wr_ptr + 1'b1;
			end
			if (res_valid)
				rd_ptr <= rd_ptr + 1'b1;	// Pop
		end
	end

	// --------------------------------------------------
	// Failure reporting
	// --------------------------------------------------
	task automatic stop_run;
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopping on first error");
	endtask

	task automatic check_failed(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
		stop_run();
	endtask

	task automatic timeout_failure(input string what);
		$display("Timeout while waiting: %s", what);
		stop_run();
	endtask

	// --------------------------------------------------
	// Assertions
	// --------------------------------------------------
	a_idle: assert property (@(posedge clk)
		idle_phase |-> (!res_valid && !err_sticky && (dz_count == '0)))
	else
		check_failed("idle outputs", 0, {$sampled(res_valid), $sampled(err_sticky), $sampled(dz_count)});

	a_latency: assert property (@(posedge clk) disable iff (reset)
		is_div_cmd |-> ##3 res_valid)
	else
		check_failed("result latency", 1, 0);

	a_no_result: assert property (@(posedge clk) disable iff (reset)
		!is_div_cmd |-> ##3 !res_valid)
	else
		check_failed("no result for nop or idle", 0, 1);

	a_quotient: assert property (@(posedge clk) disable iff (reset)
		res_valid |-> (res_quotient == exp_quot[rd_ptr]))
	else
		check_failed("quotient", exp_quot[$sampled(rd_ptr)], $sampled(res_quotient));

	a_status: assert property (@(posedge clk) disable iff (reset)
		res_valid |-> (res_status == exp_st[rd_ptr]))
	else
		check_failed("status", exp_st[$sampled(rd_ptr)], $sampled(res_status));

	a_tag: assert property (@(posedge clk) disable iff (reset)
		res_valid |-> (res_tag == exp_tag[rd_ptr]))
	else
		check_failed("tag order", exp_tag[$sampled(rd_ptr)], $sampled(res_tag));

	a_sticky: assert property (@(posedge clk) disable iff (reset) err_sticky == exp_sticky)
	else
		check_failed("sticky error", $sampled(exp_sticky), $sampled(err_sticky));

	a_dz_count: assert property (@(posedge clk) disable iff (reset) dz_count == exp_dz)
	else
		check_failed("divide-by-zero count", $sampled(exp_dz), $sampled(dz_count));

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------
	task automatic send_cmd
	(
		input div_op_t op,
		input logic [`DIV_A_WIDTH-1:0] a,
		input logic [`DIV_B_WIDTH-1:0] b
	);
		@(posedge clk);
		cmd_valid <= 1'b1;
		cmd_op    <= op;
		cmd_a     <= a;
		cmd_b     <= b;
		cmd_tag   <= next_tag;
		next_tag = next_tag + 1'b1;
	endtask

	// Ends the strobe train, then waits for every result
	task automatic drain_pipeline;
		int waited;

		waited = 0;
		@(posedge clk);
		cmd_valid <= 1'b0;
		@(negedge clk);
		while (rd_ptr != wr_ptr)
		begin
			@(negedge clk);
			waited++;
			if (waited > 20)
				timeout_failure("results did not drain from the pipeline");
		end
	endtask

	task automatic send_random_burst(input int count);
		logic [`DIV_B_WIDTH-1:0] b;
		int pick;

		for (int n = 0; n < count; n++)
		begin
			pick = $urandom_range(0, 4);
			b = $urandom;
			if (b == '0)
				b = 1;	// Keeps the divisor non-zero
			send_cmd((pick == 0) ? OP_NOP : ((pick < 3) ? OP_DIVU : OP_DIVS), $urandom, b);
		end
	endtask

	initial
	begin
		cmd_valid  = 1'b0;
		cmd_op     = OP_NOP;
		cmd_a      = '0;
		cmd_b      = '0;
		cmd_tag    = '0;
		next_tag   = '0;
		void'($urandom(16536));

		i = 0;
		while (reset !== 1'b0)	// Reset release
		begin
			@(posedge clk);
			i++;
			if (i > 30)
				timeout_failure("reset was never released");
		end
		repeat (3) @(posedge clk);

		send_random_burst(40);	// Back-to-back mix of divides and nops
		drain_pipeline();

		send_cmd(OP_DIVU, $urandom, '0);	// Zero divisors
		send_cmd(OP_DIVS, 16'h1234, '0);
		send_cmd(OP_DIVS, '0, '0);
		send_cmd(OP_DIVS, 16'hF00D, '0);
		drain_pipeline();

		send_cmd(OP_CLR, '0, '0);
		send_cmd(OP_DIVU, MOST_NEG, MINUS_ONE);	// Plain unsigned quotient
		drain_pipeline();
		repeat (4) @(posedge clk);

		send_cmd(OP_DIVS, MOST_NEG, MINUS_ONE);	// Signed overflow
		send_cmd(OP_DIVU, $urandom, '0);
		drain_pipeline();
		send_cmd(OP_CLR, '0, '0);
		send_random_burst(20);
		drain_pipeline();
		repeat (5) @(posedge clk);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+design
design/div_cmd_pkg.sv
design/div_status_pkg.sv
design/div_core.sv
design/div_decode.sv
design/div_execute.sv
design/div_result.sv
design/div_unit.sv
testbench/tb_clock_gen.sv
testbench/div_unit_tb.sv
